// ==== rtl/scb_pkg.sv ====
package scb_pkg;

    localparam int PADDR_W    = 32;
    localparam int OFFSET_W   = 5;
    localparam int BANKS      = 4;
    localparam int LINE_BYTES = 32;
    localparam int WORD_BYTES = 8;
    localparam int DC_IDX_W   = 3;

    typedef logic [PADDR_W-1:0]          paddr_t;
    typedef logic [PADDR_W-OFFSET_W-1:0] line_addr_t;
    typedef logic [$clog2(BANKS)-1:0]    bank_t;
    typedef logic [8*WORD_BYTES-1:0]     word_t;
    typedef logic [WORD_BYTES-1:0]       bmask_t;
    typedef logic [8*LINE_BYTES-1:0]     line_data_t;
    typedef logic [LINE_BYTES-1:0]       line_mask_t;
    typedef logic [DC_IDX_W-1:0]         dc_idx_t;

    typedef struct packed {
        logic   en;
        paddr_t addr;
        word_t  data;
        bmask_t mask;
    } store_req_t;

    typedef struct packed {
        word_t  data;
        bmask_t mask;
    } fwd_rsp_t;

    typedef struct packed {
        dc_idx_t    idx;
        paddr_t     paddr;
        line_data_t data;
        line_mask_t mask;
    } dc_write_t;

    function automatic line_addr_t line_of(input paddr_t addr);
        return addr[PADDR_W-1:OFFSET_W];
    endfunction

    function automatic bank_t bank_of(input paddr_t addr);
        return addr[OFFSET_W-1:OFFSET_W-$bits(bank_t)];
    endfunction

endpackage

// ==== rtl/scb_entry_ctrl.sv ====
`timescale 1ns/1ps

module scb_entry_ctrl #(
    parameter int ENTRIES = 8,
    parameter int SETTLE  = 4
) (
    input  logic                       clk,
    input  logic                       rst,
    input  scb_pkg::store_req_t        stage,
    input  logic                       ld_en,
    input  scb_pkg::paddr_t            ld_addr,
    input  logic                       dc_ready,
    input  logic                       dc_done,
    input  logic [$clog2(ENTRIES)-1:0] dc_done_idx,
    output logic                       st_stall,
    output logic                       wr_en,
    output logic [$clog2(ENTRIES)-1:0] wr_idx,
    output logic                       wr_new,
    output logic                       fwd_hit,
    output logic [$clog2(ENTRIES)-1:0] fwd_idx,
    output logic                       drain_go,
    output logic [$clog2(ENTRIES)-1:0] drain_idx,
    output scb_pkg::line_addr_t        drain_line
);
    import scb_pkg::*;

    typedef logic [$clog2(ENTRIES)-1:0] idx_t;

    localparam logic [SETTLE-1:0] SETTLE_TOP = {1'b1, {(SETTLE-1){1'b0}}};

    logic [ENTRIES-1:0] valid_q;
    logic [ENTRIES-1:0] drain_q;
    line_addr_t         line_q [ENTRIES];

    logic [ENTRIES-1:0] st_match;
    logic [ENTRIES-1:0] ld_match;
    logic [ENTRIES-1:0] wr_vec;
    logic [ENTRIES-1:0] settled;
    logic [ENTRIES-1:0] drain_cand;

    line_addr_t st_line;
    line_addr_t ld_line;
    logic       st_hit;
    logic       st_hit_drain;
    logic       any_free;
    idx_t       st_idx;
    idx_t       free_idx;

    // Lowest set bit wins.
    function automatic idx_t first_set(input logic [ENTRIES-1:0] vec);
        idx_t idx;
        idx = '0;
        for (int i = ENTRIES - 1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = idx_t'(i);
            end
        end
        return idx;
    endfunction

    assign st_line = line_of(stage.addr);
    assign ld_line = line_of(ld_addr);

    // ##################################################
    // Per-entry match and settle counters
    // ##################################################

    for (genvar i = 0; i < ENTRIES; i++) begin : g_entry
        logic [SETTLE-1:0] settle_q;

        assign st_match[i] = valid_q[i] && (line_q[i] == st_line);
        assign ld_match[i] = valid_q[i] && (line_q[i] == ld_line);
        assign wr_vec[i]   = wr_en && (wr_idx == idx_t'(i));
        assign settled[i]  = (settle_q == '0);

        // Reloaded on every write, then walks down to zero.
        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                settle_q <= '0;
            end else if (wr_vec[i]) begin
                settle_q <= SETTLE_TOP;
            end else begin
                settle_q <= settle_q >> 1;
            end
        end

        a_settle_onehot: assert property (@(posedge clk) disable iff (rst)
            $onehot0(settle_q))
            else $error("settle counter %0d not one-hot", i);
    end

    // ##################################################
    // Store merge, allocate or stall
    // ##################################################

    assign st_hit       = |st_match;
    assign st_hit_drain = |(st_match & drain_q);
    assign any_free     = ~&valid_q;
    assign st_idx       = first_set(st_match);
    assign free_idx     = first_set(~valid_q);

    assign st_stall = stage.en && (st_hit_drain || (!st_hit && !any_free));
    assign wr_en    = stage.en && !st_stall;
    assign wr_new   = !st_hit;
    assign wr_idx   = st_hit ? st_idx : free_idx;

    // Line tags are only meaningful while the entry is valid.
    always_ff @(posedge clk) begin
        if (wr_en && wr_new) begin
            line_q[wr_idx] <= st_line;
        end
    end

    // Load lookup, draining entries still forward.
    assign fwd_hit = ld_en && (|ld_match);
    assign fwd_idx = first_set(ld_match);

    // ##################################################
    // Drain selection and release
    // ##################################################

    // An entry written this cycle would be read stale by the drain.
    assign drain_cand = valid_q & ~drain_q & settled & ~wr_vec;
    assign drain_go   = dc_ready && (|drain_cand);
    assign drain_idx  = first_set(drain_cand);
    assign drain_line = line_q[drain_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
            drain_q <= '0;
        end else begin
            if (wr_en && wr_new) begin
                valid_q[wr_idx] <= 1'b1;
                drain_q[wr_idx] <= 1'b0;
            end
            if (drain_go) begin
                drain_q[drain_idx] <= 1'b1;
            end
            if (dc_done) begin
                valid_q[dc_done_idx] <= 1'b0;
                drain_q[dc_done_idx] <= 1'b0;
            end
        end
    end

    a_done_draining: assert property (@(posedge clk) disable iff (rst)
        dc_done |-> valid_q[dc_done_idx] && drain_q[dc_done_idx])
        else $error("dc_done for entry %0d that is not draining", dc_done_idx);

    a_no_write_draining: assert property (@(posedge clk) disable iff (rst)
        wr_en |-> !drain_q[wr_idx])
        else $error("store written into draining entry %0d", wr_idx);

endmodule

// ==== rtl/scb_data_store.sv ====
`timescale 1ns/1ps

module scb_data_store #(
    parameter int ENTRIES = 8
) (
    input  logic                       clk,
    input  logic                       wr_en,
    input  logic [$clog2(ENTRIES)-1:0] wr_idx,
    input  logic                       wr_new,
    input  scb_pkg::bank_t             wr_bank,
    input  scb_pkg::word_t             wr_data,
    input  scb_pkg::bmask_t            wr_mask,
    input  logic [$clog2(ENTRIES)-1:0] rd_idx,
    input  scb_pkg::bank_t             rd_bank,
    input  logic [$clog2(ENTRIES)-1:0] line_idx,
    output scb_pkg::word_t             rd_word,
    output scb_pkg::bmask_t            rd_bmask,
    output scb_pkg::line_data_t        line_data,
    output scb_pkg::line_mask_t        line_mask
);
    import scb_pkg::*;

    word_t  data_q [ENTRIES][BANKS];
    bmask_t vld_q  [ENTRIES][BANKS];

    // ##################################################
    // Masked byte write
    // ##################################################

    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int k = 0; k < WORD_BYTES; k++) begin
                if (wr_mask[k]) begin
                    data_q[wr_idx][wr_bank][8*k +: 8] <= wr_data[8*k +: 8];
                end
            end
        end
    end

    // Fresh entry drops every old valid bit.
    // The written bank's update below takes priority.
    always_ff @(posedge clk) begin
        if (wr_en) begin
            if (wr_new) begin
                for (int b = 0; b < BANKS; b++) begin
                    vld_q[wr_idx][b] <= '0;
                end
                vld_q[wr_idx][wr_bank] <= wr_mask;
            end else begin
                vld_q[wr_idx][wr_bank] <= vld_q[wr_idx][wr_bank] | wr_mask;
            end
        end
    end

    // ##################################################
    // Combinational reads
    // ##################################################

    assign rd_word  = data_q[rd_idx][rd_bank];
    assign rd_bmask = vld_q[rd_idx][rd_bank];

    // Bank 0 sits in the low bits of the line.
    always_comb begin
        for (int b = 0; b < BANKS; b++) begin
            line_data[$bits(word_t)*b +: $bits(word_t)] = data_q[line_idx][b];
            line_mask[WORD_BYTES*b +: WORD_BYTES]       = vld_q[line_idx][b];
        end
    end

endmodule

// ==== rtl/scb_response_stage.sv ====
`timescale 1ns/1ps

module scb_response_stage #(
    parameter int ENTRIES = 8
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       ld_en,
    input  logic                       fwd_hit,
    input  scb_pkg::word_t             rd_word,
    input  scb_pkg::bmask_t            rd_bmask,
    input  logic                       drain_go,
    input  logic [$clog2(ENTRIES)-1:0] drain_idx,
    input  scb_pkg::line_addr_t        drain_line,
    input  scb_pkg::line_data_t        line_data,
    input  scb_pkg::line_mask_t        line_mask,
    output scb_pkg::fwd_rsp_t          fwd,
    output logic                       dc_req,
    output scb_pkg::dc_write_t         dc_wr
);
    import scb_pkg::*;

    word_t     fwd_data_q;
    bmask_t    fwd_mask_q;
    logic      dc_req_q;
    dc_write_t dc_wr_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fwd_mask_q <= '0;
            dc_req_q   <= 1'b0;
        end else begin
            fwd_mask_q <= (ld_en && fwd_hit) ? rd_bmask : '0;
            dc_req_q   <= drain_go;
        end
    end

    // Payload, only meaningful under its mask or strobe.
    always_ff @(posedge clk) begin
        fwd_data_q <= rd_word;
        if (drain_go) begin
            dc_wr_q.idx   <= dc_idx_t'(drain_idx);
            dc_wr_q.paddr <= {drain_line, {OFFSET_W{1'b0}}};
            dc_wr_q.data  <= line_data;
            dc_wr_q.mask  <= line_mask;
        end
    end

    assign fwd    = '{data: fwd_data_q, mask: fwd_mask_q};
    assign dc_req = dc_req_q;
    assign dc_wr  = dc_wr_q;

    // A drained entry always holds at least one written byte.
    a_drain_nonempty: assert property (@(posedge clk) disable iff (rst)
        dc_req |-> (|dc_wr.mask))
        else $error("drain of entry %0d with empty mask", dc_wr.idx);

endmodule

// ==== rtl/store_commit_buffer.sv ====
`timescale 1ns/1ps

module store_commit_buffer #(
    parameter int ENTRIES = 8,
    parameter int SETTLE  = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  scb_pkg::store_req_t st,
    output logic                st_stall,
    input  logic                ld_en,
    input  scb_pkg::paddr_t     ld_addr,
    output scb_pkg::fwd_rsp_t   fwd,
    input  logic                dc_ready,
    input  logic                dc_done,
    input  scb_pkg::dc_idx_t    dc_done_idx,
    output logic                dc_req,
    output scb_pkg::dc_write_t  dc_wr
);
    import scb_pkg::*;

    typedef logic [$clog2(ENTRIES)-1:0] idx_t;

    store_req_t stage_q;

    logic       wr_en;
    logic       wr_new;
    idx_t       wr_idx;
    logic       fwd_hit;
    idx_t       fwd_idx;
    logic       drain_go;
    idx_t       drain_idx;
    line_addr_t drain_line;
    word_t      rd_word;
    bmask_t     rd_bmask;
    line_data_t line_data;
    line_mask_t line_mask;

    // ##################################################
    // Store input stage
    // ##################################################

    // Holds while stalled, upstream keeps st stable.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stage_q <= '0;
        end else if (!st_stall) begin
            stage_q <= st;
        end
    end

    scb_entry_ctrl #(
        .ENTRIES (ENTRIES),
        .SETTLE  (SETTLE)
    ) u_entry_ctrl (
        .clk         (clk),
        .rst         (rst),
        .stage       (stage_q),
        .ld_en       (ld_en),
        .ld_addr     (ld_addr),
        .dc_ready    (dc_ready),
        .dc_done     (dc_done),
        .dc_done_idx (idx_t'(dc_done_idx)),
        .st_stall    (st_stall),
        .wr_en       (wr_en),
        .wr_idx      (wr_idx),
        .wr_new      (wr_new),
        .fwd_hit     (fwd_hit),
        .fwd_idx     (fwd_idx),
        .drain_go    (drain_go),
        .drain_idx   (drain_idx),
        .drain_line  (drain_line)
    );

    scb_data_store #(
        .ENTRIES (ENTRIES)
    ) u_data_store (
        .clk       (clk),
        .wr_en     (wr_en),
        .wr_idx    (wr_idx),
        .wr_new    (wr_new),
        .wr_bank   (bank_of(stage_q.addr)),
        .wr_data   (stage_q.data),
        .wr_mask   (stage_q.mask),
        .rd_idx    (fwd_idx),
        .rd_bank   (bank_of(ld_addr)),
        .line_idx  (drain_idx),
        .rd_word   (rd_word),
        .rd_bmask  (rd_bmask),
        .line_data (line_data),
        .line_mask (line_mask)
    );

    scb_response_stage #(
        .ENTRIES (ENTRIES)
    ) u_response_stage (
        .clk        (clk),
        .rst        (rst),
        .ld_en      (ld_en),
        .fwd_hit    (fwd_hit),
        .rd_word    (rd_word),
        .rd_bmask   (rd_bmask),
        .drain_go   (drain_go),
        .drain_idx  (drain_idx),
        .drain_line (drain_line),
        .line_data  (line_data),
        .line_mask  (line_mask),
        .fwd        (fwd),
        .dc_req     (dc_req),
        .dc_wr      (dc_wr)
    );

endmodule

// ==== sim/scb_tb.sv ====
`timescale 1ns/1ps

module scb_tb;
    import scb_pkg::*;

    localparam int ENTRIES = 8;
    localparam int SETTLE  = 4;
    localparam int TIMEOUT = 400;

    logic       clk;
    logic       rst;
    store_req_t st;
    logic       st_stall;
    logic       ld_en;
    paddr_t     ld_addr;
    fwd_rsp_t   fwd;
    logic       dc_ready;
    logic       dc_done;
    dc_idx_t    dc_done_idx;
    logic       dc_req;
    dc_write_t  dc_wr;

    logic [7:0] ref_mem [paddr_t];
    logic [7:0] cache_mem [paddr_t];
    line_mask_t buf_mask [line_addr_t];
    dc_idx_t    line_ent [line_addr_t];
    time        ent_free_at [ENTRIES];
    int         done_due [$];
    dc_idx_t    done_idx [$];
    line_addr_t done_line [$];

    store_req_t staged;
    logic       last_stall;
    logic [2:0] hist;
    int         cache_mode;

    store_commit_buffer #(.ENTRIES(ENTRIES), .SETTLE(SETTLE)) UUT (
        .clk(clk), .rst(rst), .st(st), .st_stall(st_stall),
        .ld_en(ld_en), .ld_addr(ld_addr), .fwd(fwd),
        .dc_ready(dc_ready), .dc_done(dc_done), .dc_done_idx(dc_done_idx),
        .dc_req(dc_req), .dc_wr(dc_wr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped");
    endtask

    // ##################################################
    // Reference model
    // ##################################################

    function automatic word_t expand(input bmask_t m);
        word_t w;
        for (int k = 0; k < 8; k++) begin
            w[8*k +: 8] = {8{m[k]}};
        end
        return w;
    endfunction

    function automatic word_t mem_word(input paddr_t addr);
        word_t  w;
        paddr_t a;
        w = '0;
        for (int k = 0; k < 8; k++) begin
            a = {addr[31:3], 3'b000} + paddr_t'(k);
            if (ref_mem.exists(a)) begin
                w[8*k +: 8] = ref_mem[a];
            end
        end
        return w;
    endfunction

    function automatic fwd_rsp_t expect_fwd(input paddr_t addr);
        fwd_rsp_t   r;
        line_mask_t lm;
        lm = buf_mask.exists(line_of(addr)) ? buf_mask[line_of(addr)] : '0;
        r.mask = lm[8*bank_of(addr) +: 8];
        r.data = mem_word(addr) & expand(r.mask);
        return r;
    endfunction

    function automatic dc_write_t expect_line(input line_addr_t l);
        dc_write_t w;
        w.idx   = line_ent.exists(l) ? line_ent[l] : '0;
        w.paddr = {l, 5'b00000};
        w.mask  = buf_mask.exists(l) ? buf_mask[l] : '0;
        for (int b = 0; b < BANKS; b++) begin
            w.data[64*b +: 64] = mem_word(w.paddr + paddr_t'(8*b)) & expand(w.mask[8*b +: 8]);
        end
        return w;
    endfunction

    // Lowest entry whose release reaches the DUT before the next edge.
    function automatic dc_idx_t alloc_entry();
        for (int i = 0; i < ENTRIES; i++) begin
            if (ent_free_at[i] < $time) begin
                ent_free_at[i] = '1;
                return dc_idx_t'(i);
            end
        end
        return '0;
    endfunction

    task automatic record_store(input store_req_t s);
        line_mask_t lm;
        paddr_t     a;
        if (!buf_mask.exists(line_of(s.addr))) begin
            line_ent[line_of(s.addr)] = alloc_entry();
        end
        lm = buf_mask.exists(line_of(s.addr)) ? buf_mask[line_of(s.addr)] : '0;
        for (int k = 0; k < 8; k++) begin
            if (s.mask[k]) begin
                a = {s.addr[31:3], 3'b000} + paddr_t'(k);
                ref_mem[a] = s.data[8*k +: 8];
                lm[8*bank_of(s.addr) + k] = 1'b1;
            end
        end
        buf_mask[line_of(s.addr)] = lm;
    endtask

    // ##################################################
    // Compare tasks
    // ##################################################

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED at %0t: %s got %0b expected %0b", $time, name, got, exp));
        end
    endtask

    task automatic check_fwd(input fwd_rsp_t got, input fwd_rsp_t exp);
        if (got.mask !== exp.mask || (got.data & expand(exp.mask)) !== exp.data) begin
            abort_run($sformatf("FAILED at %0t: fwd got %h/%h expected %h/%h", $time,
                                got.data, got.mask, exp.data, exp.mask));
        end
    endtask

    task automatic check_dc(input dc_write_t got, input dc_write_t exp);
        line_data_t m;
        for (int b = 0; b < BANKS; b++) begin
            m[64*b +: 64] = expand(exp.mask[8*b +: 8]);
        end
        if (got.idx !== exp.idx || got.paddr !== exp.paddr || got.mask !== exp.mask
                || (got.data & m) !== exp.data) begin
            abort_run($sformatf("FAILED at %0t: dc_wr got %0d/%h/%h/%h expected %0d/%h/%h/%h",
                                $time, got.idx, got.paddr, got.mask, got.data,
                                exp.idx, exp.paddr, exp.mask, exp.data));
        end
    endtask

    task automatic check_word(input paddr_t addr, input word_t got, input word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED at %0t: cache word %h got %h expected %h", $time,
                                addr, got, exp));
        end
    endtask

    // Data cache model. Done pulses return in request order.
    initial begin : cache_model
        int        now;
        int        due;
        dc_write_t w;
        dc_ready    = 1'b0;
        dc_done     = 1'b0;
        dc_done_idx = '0;
        now         = 0;
        due         = 0;
        forever begin
            @(posedge clk);
            #1;
            now++;
            dc_done = 1'b0;
            if (dc_req) begin
                w = dc_wr;
                check_dc(w, expect_line(line_of(w.paddr)));
                for (int k = 0; k < LINE_BYTES; k++) begin
                    if (w.mask[k]) begin
                        cache_mem[w.paddr + paddr_t'(k)] = w.data[8*k +: 8];
                    end
                end
                due = (due > now) ? due + 1 : now + int'($urandom_range(6, 1));
                done_due.push_back(due);
                done_idx.push_back(w.idx);
                done_line.push_back(line_of(w.paddr));
            end
            if (done_due.size() > 0 && done_due[0] <= now) begin
                dc_done     = 1'b1;
                dc_done_idx = done_idx.pop_front();
                ent_free_at[dc_done_idx] = $time;
                buf_mask.delete(done_line.pop_front());
                void'(done_due.pop_front());
            end
            case (cache_mode)
                0: dc_ready = 1'b0;
                1: dc_ready = 1'b1;
                default: dc_ready = 1'($urandom_range(1, 0));
            endcase
        end
    end

    // ##################################################
    // Stimulus helpers
    // ##################################################

    // One cycle; mirrors the stage register and records accepted stores.
    task automatic tick(input store_req_t next, output logic took);
        @(posedge clk);
        #1;
        if (!last_stall) begin
            staged = st;
        end
        hist       = {hist[1:0], staged.en};
        last_stall = st_stall;
        if (staged.en && !st_stall) begin
            record_store(staged);
        end
        took = !st_stall;
        if (!st_stall) begin
            st = next;
        end
    endtask

    task automatic send_store(input paddr_t addr, input word_t data, input bmask_t mask);
        logic took;
        int   n;
        took = 1'b0;
        n    = 0;
        while (!took) begin
            tick('{en: 1'b1, addr: addr, data: data, mask: mask}, took);
            if (++n > TIMEOUT) abort_run("store never left the input stage");
        end
    endtask

    task automatic quiet(input int cycles);
        logic took;
        repeat (cycles) tick('0, took);
    endtask

    task automatic load_check(input paddr_t addr);
        fwd_rsp_t exp;
        logic     took;
        ld_en   = 1'b1;
        ld_addr = addr;
        exp     = expect_fwd(addr);
        tick('0, took);
        ld_en = 1'b0;
        check_fwd(fwd, exp);
    endtask

    task automatic drain_all();
        logic took;
        int   n;
        cache_mode = 1;
        n          = 0;
        while (buf_mask.size() != 0 || done_due.size() != 0 || hist != 0) begin
            tick('0, took);
            if (++n > TIMEOUT) abort_run("buffer did not drain");
        end
        quiet(2);
    endtask

    initial begin : main
        paddr_t     a;
        store_req_t nxt;
        logic       took;
        logic       chk;
        word_t      snap;
        int         n;
        void'($urandom(32'h1bae0124));
        rst = 1'b1;
        st = '0;
        ld_en = 1'b0;
        ld_addr = '0;
        staged = '0;
        last_stall = 1'b0;
        hist = '0;
        cache_mode = 0;
        foreach (ent_free_at[i]) begin
            ent_free_at[i] = 0;
        end
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        check_level("st_stall", st_stall, 1'b0);
        check_level("dc_req", dc_req, 1'b0);
        check_level("fwd.mask", |fwd.mask, 1'b0);

        // Merging within one line.
        send_store(32'h0000_1000, 64'h1111_2222_3333_4444, 8'h0f);
        send_store(32'h0000_1010, 64'h5555_6666_7777_8888, 8'hf0);
        send_store(32'h0000_1008, 64'h99aa_bbcc_ddee_ff00, 8'h3c);
        send_store(32'h0000_1008, 64'h0102_0304_0506_0708, 8'h0f);
        quiet(3);
        for (int b = 0; b < BANKS; b++) load_check(32'h0000_1000 + paddr_t'(8*b));
        drain_all();
        cache_mode = 0;

        // Fill every entry, then one more line must stall.
        for (int i = 0; i < ENTRIES; i++) begin
            send_store(32'h0000_4000 + paddr_t'(32*i), {2{32'hcafe_0000 + i}}, 8'hff);
        end
        send_store(32'h0000_4028, 64'h0bad_f00d_0bad_f00d, 8'h81);
        send_store(32'h0000_8000, 64'hdead_beef_dead_beef, 8'hff);
        tick('0, took);
        repeat (3) begin
            check_level("st_stall", st_stall, 1'b1);
            tick('0, took);
        end

        // Drain frees an entry for the pending store.
        cache_mode = 1;
        n = 0;
        while (!took) begin
            tick('0, took);
            if (++n > TIMEOUT) abort_run("pending store never accepted");
        end
        drain_all();
        load_check(32'h0000_4000);

        // Random traffic over a few more lines than entries.
        cache_mode = 2;
        nxt = '0;
        chk = 1'b0;
        snap = '0;
        for (int c = 0; c < 2000; c++) begin
            tick(nxt, took);
            if (chk) check_fwd(fwd, '{data: snap & expand(fwd.mask), mask: fwd.mask});
            chk = 1'b0;
            ld_en = 1'b0;
            if (took) begin
                a = 32'h0002_0000 + paddr_t'(32 * $urandom_range(11, 0) + 8 * $urandom_range(3, 0));
                nxt = '{en: 1'($urandom_range(1, 0)), addr: a, data: {$urandom, $urandom},
                        mask: bmask_t'($urandom_range(255, 1))};
            end
            if ($urandom_range(2, 0) == 0) begin
                ld_en   = 1'b1;
                ld_addr = 32'h0002_0000 + paddr_t'(32 * $urandom_range(11, 0)
                                                   + 8 * $urandom_range(3, 0));
                chk     = (hist == 0);
                snap    = mem_word(ld_addr);
            end
        end
        ld_en = 1'b0;
        st = '0;
        drain_all();

        foreach (ref_mem[k]) begin
            if (!cache_mem.exists(k)) abort_run($sformatf("cache never wrote byte %h", k));
            check_word(k, {56'h0, cache_mem[k]}, {56'h0, ref_mem[k]});
        end
        foreach (cache_mem[k]) begin
            if (!ref_mem.exists(k)) abort_run($sformatf("cache wrote unknown byte %h", k));
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

// ==== store_commit_buffer.f ====
rtl/scb_pkg.sv
rtl/scb_entry_ctrl.sv
rtl/scb_data_store.sv
rtl/scb_response_stage.sv
rtl/store_commit_buffer.sv
sim/scb_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds and runs the store commit buffer testbench with Verilator.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    -f store_commit_buffer.f \
    --top-module scb_tb \
    --Mdir obj_dir -o scb_sim

./obj_dir/scb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
grep -q "Result: PASSED" sim.log
